// File: hdl/dma_sched_pkg.sv
package dma_sched_pkg;

  // ------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------
  localparam int NUM_SLOTS = 8;
  localparam int SLOT_W    = 3;
  localparam int BLOCK_MAX = 64;  // words
  localparam int PAGE_BITS = 8;   // page is 2^PAGE_BITS words
  localparam int LEN_W     = 24;
  localparam int ADDR_W    = 32;
  localparam int CHAN_W    = 2;
  localparam int CNT_W     = 7;   // holds BLOCK_MAX

  // ------------------------------------------------------------
  // structs
  // ------------------------------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [1:0]        section;
  } desc_t;

  // one block for the mover
  typedef struct packed {
    logic [CHAN_W-1:0] chan;
    logic [1:0]        section;
    logic [ADDR_W-1:0] addr;
    logic [CNT_W-1:0]  count;
  } blk_req_t;

  typedef struct packed {
    logic [SLOT_W-1:0] slot;
    desc_t             desc;
  } dispatch_t;

  typedef struct packed {
    logic              valid;
    logic [SLOT_W-1:0] slot;
  } cmpl_t;

  // ------------------------------------------------------------
  // enums
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    EX_IDLE,
    EX_SIZE,
    EX_ISSUE,
    EX_WAIT,
    EX_DONE
  } exec_state_e;

  // paddr[2]
  typedef enum logic {
    REG_ADDR = 1'b0,
    REG_CTRL = 1'b1
  } reg_sel_e;

endpackage

// File: hdl/desc_mem.sv
`timescale 1ns/100ps

module desc_mem
  import dma_sched_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [5:0]        paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  input  logic [SLOT_W-1:0] sched_slot,
  output desc_t             sched_desc,
  output logic              sched_claimable,
  input  logic              claim,
  input  logic [SLOT_W-1:0] claim_slot,
  input  cmpl_t             cmpl
);

  desc_t                mem [NUM_SLOTS];
  logic [NUM_SLOTS-1:0] active;
  logic [NUM_SLOTS-1:0] busy;   // claimed by an executor

  logic [SLOT_W-1:0] apb_slot;
  reg_sel_e          apb_reg;
  logic              apb_setup;
  logic              apb_wr;
  logic              wr_ok;

  assign apb_slot  = paddr[5:3];
  assign apb_reg   = reg_sel_e'(paddr[2]);
  assign apb_setup = psel && !penable;
  assign apb_wr    = psel && penable && pwrite;
  assign wr_ok     = apb_wr && !active[apb_slot];

  assign pready  = 1'b1;
  assign pslverr = apb_wr && active[apb_slot];  // slot locked while active

  // ------------------------------------------------------------
  // APB side
  // ------------------------------------------------------------
  always_ff @(posedge CLK)
  begin
    if (apb_setup && !pwrite)  // data ready for the access phase
    begin
      if (apb_reg == REG_CTRL)
        prdata <= {active[apb_slot], 5'd0, mem[apb_slot].section, mem[apb_slot].len};
      else
        prdata <= mem[apb_slot].addr;
    end
    if (wr_ok)
    begin
      if (apb_reg == REG_CTRL)
      begin
        mem[apb_slot].len     <= pwdata[LEN_W-1:0];
        mem[apb_slot].section <= pwdata[25:24];
      end
      else
        mem[apb_slot].addr <= pwdata;
    end
  end

  // ------------------------------------------------------------
  // flags and scheduler port
  // ------------------------------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      active          <= '0;
      busy            <= '0;
      sched_claimable <= 1'b0;
    end
    else
    begin
      if (wr_ok && apb_reg == REG_CTRL)
        active[apb_slot] <= pwdata[31];
      if (claim)
        busy[claim_slot] <= 1'b1;
      if (cmpl.valid)
      begin
        active[cmpl.slot] <= 1'b0;
        busy[cmpl.slot]   <= 1'b0;
      end
      sched_claimable <= active[sched_slot] && !busy[sched_slot];
    end
  end

  always_ff @(posedge CLK)
  begin
    sched_desc <= mem[sched_slot];
  end

endmodule

// File: hdl/carousel_sched.sv
`timescale 1ns/100ps

module carousel_sched
  import dma_sched_pkg::*;
#(
  parameter int NUM_CHAN = 4
)
(
  input  logic                CLK,
  input  logic                RST,
  output logic [SLOT_W-1:0]   sched_slot,
  input  desc_t               sched_desc,
  input  logic                sched_claimable,
  output logic                claim,
  output logic [SLOT_W-1:0]   claim_slot,
  input  logic [NUM_CHAN-1:0] exec_idle,
  output logic [NUM_CHAN-1:0] dispatch_valid,
  output dispatch_t           dispatch
);

  logic [SLOT_W-1:0]   slot_ptr;
  logic [SLOT_W-1:0]   rd_slot;   // slot of the read coming back now
  logic                claim_d;
  logic [NUM_CHAN-1:0] idle_low;

  assign sched_slot = slot_ptr;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      slot_ptr <= '0;
      rd_slot  <= '0;
      claim_d  <= 1'b0;
    end
    else
    begin
      if (slot_ptr == SLOT_W'(NUM_SLOTS - 1))
        slot_ptr <= '0;
      else
        slot_ptr <= slot_ptr + 1'b1;
      rd_slot <= slot_ptr;
      claim_d <= claim;
    end
  end

  // isolate lowest set bit
  assign idle_low = exec_idle & (~exec_idle + 1'b1);

  // no claim right after a claim, the returning read may be stale
  assign claim      = sched_claimable && (|exec_idle) && !claim_d;
  assign claim_slot = rd_slot;

  assign dispatch_valid = claim ? idle_low : '0;
  assign dispatch       = '{slot: rd_slot, desc: sched_desc};

endmodule

// File: hdl/block_exec.sv
`timescale 1ns/100ps

module block_exec
  import dma_sched_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              dispatch_valid,
  input  dispatch_t         dispatch,
  output logic              exec_idle,
  output logic              req_valid,
  output blk_req_t          req,
  input  logic              req_grant,
  input  logic              blk_done_chan,
  output logic              done_valid,
  output logic [SLOT_W-1:0] done_slot,
  input  logic              done_grant
);

  exec_state_e       state;
  logic [SLOT_W-1:0] slot;
  logic [1:0]        section;
  logic [ADDR_W-1:0] addr;     // next word to move
  logic [LEN_W-1:0]  remain;
  logic [CNT_W-1:0]  count;    // block in flight

  logic [PAGE_BITS:0] page_left;
  logic [LEN_W-1:0]   next_len;

  // 1 .. 2^PAGE_BITS words
  assign page_left = {1'b1, {PAGE_BITS{1'b0}}} - {1'b0, addr[PAGE_BITS-1:0]};

  // min of remaining, BLOCK_MAX, page room
  always_comb
  begin
    next_len = LEN_W'(BLOCK_MAX);
    if (remain < next_len)
      next_len = remain;
    if (LEN_W'(page_left) < next_len)
      next_len = LEN_W'(page_left);
  end

  // ------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
      state <= EX_IDLE;
    else
    begin
      case (state)
        EX_IDLE:
          if (dispatch_valid)
            state <= EX_SIZE;
        EX_SIZE:
          state <= (remain == '0) ? EX_DONE : EX_ISSUE;
        EX_ISSUE:
          if (req_grant)
            state <= EX_WAIT;
        EX_WAIT:
          if (blk_done_chan)
            state <= (remain == LEN_W'(count)) ? EX_DONE : EX_SIZE;
        EX_DONE:
          if (done_grant)
            state <= EX_IDLE;
        default:
          state <= EX_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (state == EX_IDLE && dispatch_valid)
    begin
      slot    <= dispatch.slot;
      section <= dispatch.desc.section;
      addr    <= dispatch.desc.addr;
      remain  <= dispatch.desc.len;
    end
    if (state == EX_SIZE)
      count <= next_len[CNT_W-1:0];
    if (state == EX_WAIT && blk_done_chan)
    begin
      addr   <= addr + ADDR_W'(count);
      remain <= remain - LEN_W'(count);
    end
  end

  assign exec_idle  = (state == EX_IDLE);
  assign req_valid  = (state == EX_ISSUE);
  assign done_valid = (state == EX_DONE);
  assign done_slot  = slot;

  // chan gets tagged per instance at the top level
  assign req = '{chan: {CHAN_W{1'b0}}, section: section, addr: addr, count: count};

endmodule

// File: hdl/block_arbiter.sv
`timescale 1ns/100ps

module block_arbiter
  import dma_sched_pkg::*;
#(
  parameter int NUM_CHAN = 4
)
(
  input  logic                CLK,
  input  logic                RST,
  input  logic [NUM_CHAN-1:0] req_valid,
  input  blk_req_t            req [NUM_CHAN],
  output logic [NUM_CHAN-1:0] req_grant,
  input  logic [NUM_CHAN-1:0] done_valid,
  input  logic [SLOT_W-1:0]   done_slot [NUM_CHAN],
  output logic [NUM_CHAN-1:0] done_grant,
  output logic                blk_valid,
  output blk_req_t            blk_req,
  input  logic                blk_ready,
  input  logic                blk_done,
  input  logic [CHAN_W-1:0]   blk_done_chan,
  output logic [NUM_CHAN-1:0] blk_done_route,
  output cmpl_t               cmpl,
  output logic                irq,
  output logic [SLOT_W-1:0]   irq_slot
);

  // {found, index}, first requester at or after ptr
  function automatic logic [CHAN_W:0] rr_pick(input logic [NUM_CHAN-1:0] vld,
                                               input logic [CHAN_W-1:0]   ptr);
    logic [CHAN_W:0] res;
    int              idx;
    res = '0;
    for (int k = NUM_CHAN - 1; k >= 0; k--)
    begin
      idx = (int'(ptr) + k) % NUM_CHAN;
      if (vld[idx])
        res = {1'b1, CHAN_W'(idx)};
    end
    return res;
  endfunction

  logic [CHAN_W-1:0] blk_ptr;
  logic [CHAN_W-1:0] done_ptr;
  logic [CHAN_W:0]   blk_pick;
  logic [CHAN_W:0]   done_pick;
  logic              blk_load;
  logic              cmpl_valid;
  logic [SLOT_W-1:0] cmpl_slot;

  assign blk_pick  = rr_pick(req_valid, blk_ptr);
  assign done_pick = rr_pick(done_valid, done_ptr);

  assign blk_load = blk_pick[CHAN_W] && (!blk_valid || blk_ready);  // slot free or draining

  assign req_grant      = blk_load ? (NUM_CHAN'(1) << blk_pick[CHAN_W-1:0]) : '0;
  assign done_grant     = done_pick[CHAN_W] ? (NUM_CHAN'(1) << done_pick[CHAN_W-1:0]) : '0;
  assign blk_done_route = blk_done ? (NUM_CHAN'(1) << blk_done_chan) : '0;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      blk_valid  <= 1'b0;
      blk_ptr    <= '0;
      done_ptr   <= '0;
      cmpl_valid <= 1'b0;
    end
    else
    begin
      if (blk_load)
      begin
        blk_valid <= 1'b1;
        blk_ptr   <= blk_pick[CHAN_W-1:0] + 1'b1;
      end
      else if (blk_ready)
        blk_valid <= 1'b0;
      cmpl_valid <= done_pick[CHAN_W];
      if (done_pick[CHAN_W])
        done_ptr <= done_pick[CHAN_W-1:0] + 1'b1;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (blk_load)
      blk_req <= req[blk_pick[CHAN_W-1:0]];
    if (done_pick[CHAN_W])
      cmpl_slot <= done_slot[done_pick[CHAN_W-1:0]];
  end

  assign cmpl     = '{valid: cmpl_valid, slot: cmpl_slot};
  assign irq      = cmpl_valid;
  assign irq_slot = cmpl_slot;

endmodule

// File: hdl/dma_sched_top.sv
`timescale 1ns/100ps

module dma_sched_top
  import dma_sched_pkg::*;
#(
  parameter int NUM_CHAN = 4
)
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [5:0]        paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              blk_valid,
  output blk_req_t          blk_req,
  input  logic              blk_ready,
  input  logic              blk_done,
  input  logic [CHAN_W-1:0] blk_done_chan,
  output logic              irq,
  output logic [SLOT_W-1:0] irq_slot
);

  logic [SLOT_W-1:0]   sched_slot;
  desc_t               sched_desc;
  logic                sched_claimable;
  logic                claim;
  logic [SLOT_W-1:0]   claim_slot;
  cmpl_t               cmpl;
  logic [NUM_CHAN-1:0] exec_idle;
  logic [NUM_CHAN-1:0] dispatch_valid;
  dispatch_t           dispatch;
  logic [NUM_CHAN-1:0] req_valid;
  blk_req_t            req [NUM_CHAN];
  logic [NUM_CHAN-1:0] req_grant;
  logic [NUM_CHAN-1:0] blk_done_route;
  logic [NUM_CHAN-1:0] done_valid;
  logic [SLOT_W-1:0]   done_slot [NUM_CHAN];
  logic [NUM_CHAN-1:0] done_grant;

  desc_mem desc_mem_i (
    .CLK             (CLK),
    .RST             (RST),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .sched_slot      (sched_slot),
    .sched_desc      (sched_desc),
    .sched_claimable (sched_claimable),
    .claim           (claim),
    .claim_slot      (claim_slot),
    .cmpl            (cmpl)
  );

  carousel_sched #(.NUM_CHAN(NUM_CHAN)) carousel_sched_i (
    .CLK             (CLK),
    .RST             (RST),
    .sched_slot      (sched_slot),
    .sched_desc      (sched_desc),
    .sched_claimable (sched_claimable),
    .claim           (claim),
    .claim_slot      (claim_slot),
    .exec_idle       (exec_idle),
    .dispatch_valid  (dispatch_valid),
    .dispatch        (dispatch)
  );

  // ------------------------------------------------------------
  // executors
  // ------------------------------------------------------------
  for (genvar i = 0; i < NUM_CHAN; i++)
  begin : g_exec
    localparam logic [CHAN_W-1:0] CHAN_IDX = CHAN_W'(i);

    blk_req_t exec_req;

    block_exec block_exec_i (
      .CLK            (CLK),
      .RST            (RST),
      .dispatch_valid (dispatch_valid[i]),
      .dispatch       (dispatch),
      .exec_idle      (exec_idle[i]),
      .req_valid      (req_valid[i]),
      .req            (exec_req),
      .req_grant      (req_grant[i]),
      .blk_done_chan  (blk_done_route[i]),
      .done_valid     (done_valid[i]),
      .done_slot      (done_slot[i]),
      .done_grant     (done_grant[i])
    );

    // stamp own channel so the mover can route blk_done back
    assign req[i] = '{chan: CHAN_IDX, section: exec_req.section,
                      addr: exec_req.addr, count: exec_req.count};
  end

  block_arbiter #(.NUM_CHAN(NUM_CHAN)) block_arbiter_i (
    .CLK            (CLK),
    .RST            (RST),
    .req_valid      (req_valid),
    .req            (req),
    .req_grant      (req_grant),
    .done_valid     (done_valid),
    .done_slot      (done_slot),
    .done_grant     (done_grant),
    .blk_valid      (blk_valid),
    .blk_req        (blk_req),
    .blk_ready      (blk_ready),
    .blk_done       (blk_done),
    .blk_done_chan  (blk_done_chan),
    .blk_done_route (blk_done_route),
    .cmpl           (cmpl),
    .irq            (irq),
    .irq_slot       (irq_slot)
  );

endmodule

// File: test/tb_dma_sched.sv
`timescale 1ns/100ps

module tb_dma_sched
  import dma_sched_pkg::*;
;

  localparam int NUM_CHAN    = 4;
  localparam int CYCLE_LIMIT = 20000;  // all tests need a few thousand cycles at most

  logic              CLK;
  logic              RST;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [5:0]        paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;
  logic              blk_valid;
  blk_req_t          blk_req;
  logic              blk_ready;
  logic              blk_done;
  logic [CHAN_W-1:0] blk_done_chan;
  logic              irq;
  logic [SLOT_W-1:0] irq_slot;

  integer seed = 2;
  int     cycle = 0;

  // reference model, per slot
  logic [31:0]          exp_addr [NUM_SLOTS];
  int                   exp_rem  [NUM_SLOTS];
  logic [1:0]           exp_sec  [NUM_SLOTS];
  logic [31:0]          desc_addr [NUM_SLOTS];  // as written over APB
  int                   desc_len  [NUM_SLOTS];
  logic [NUM_SLOTS-1:0] pending = '0;
  logic [3:0]           chan_seen = '0;
  logic                 stall_seen = 1'b0;

  // mover queue
  logic [CHAN_W-1:0] pend_chan [$];
  int                pend_due  [$];

  dma_sched_top #(.NUM_CHAN(NUM_CHAN)) dma_sched_top_i (
    .CLK           (CLK),
    .RST           (RST),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .blk_valid     (blk_valid),
    .blk_req       (blk_req),
    .blk_ready     (blk_ready),
    .blk_done      (blk_done),
    .blk_done_chan (blk_done_chan),
    .irq           (irq),
    .irq_slot      (irq_slot)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  always @(posedge CLK)
  begin
    cycle <= cycle + 1;
    if (cycle == CYCLE_LIMIT)
    begin
      $display("TIMEOUT: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic fail_check(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // ------------------------------------------------------------
  // APB
  // ------------------------------------------------------------
  function automatic logic [5:0] reg_addr(input int s, input reg_sel_e sel);
    return {s[2:0], sel, 2'b00};
  endfunction

  task automatic apb_write(input logic [5:0] a, input logic [31:0] d, output logic err);
    @(posedge CLK);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = a;
    pwdata  = d;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    @(negedge CLK);
    assert (pready === 1'b1) else fail_check("pready low in write access phase");
    err = pslverr;
    @(posedge CLK);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [5:0] a, output logic [31:0] d);
    @(posedge CLK);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = a;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    @(negedge CLK);
    assert (pready === 1'b1) else fail_check("pready low in read access phase");
    assert (pslverr === 1'b0) else fail_check("pslverr high on a read");
    d = prdata;
    @(posedge CLK);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // write a descriptor and set it active, model follows
  task automatic load_desc(input int s, input logic [31:0] a, input int len,
                           input logic [1:0] sec);
    logic err;
    desc_addr[s] = a;
    desc_len[s]  = len;
    exp_addr[s]  = a;
    exp_rem[s]   = len;
    exp_sec[s]   = sec;
    pending[s]   = 1'b1;
    apb_write(reg_addr(s, REG_ADDR), a, err);
    assert (!err) else fail_check($sformatf("pslverr on address write, slot %0d", s));
    apb_write(reg_addr(s, REG_CTRL), {1'b1, 5'd0, sec, len[23:0]}, err);
    assert (!err) else fail_check($sformatf("pslverr on control write, slot %0d", s));
  endtask

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  // smallest of words left, BLOCK_MAX and room up to the page end
  function automatic int rule_count(input logic [31:0] a, input int rem);
    int room;
    int n;
    room = (1 << PAGE_BITS) - int'(a[PAGE_BITS-1:0]);
    n    = (rem < BLOCK_MAX) ? rem : BLOCK_MAX;
    return (room < n) ? room : n;
  endfunction

  task automatic check_block(input blk_req_t b);
    int s;
    int n;
    s = -1;
    for (int k = 0; k < NUM_SLOTS; k++)
      if (pending[k] && exp_rem[k] != 0 && exp_addr[k] == b.addr)
        s = k;
    assert (s >= 0) else fail_check($sformatf("block at %h follows no pending descriptor",
                                              b.addr));
    assert ((b.addr >> PAGE_BITS) == ((b.addr + 32'(b.count) - 1) >> PAGE_BITS))
      else fail_check($sformatf("block at %h of %0d words crosses a page", b.addr, b.count));
    n = rule_count(exp_addr[s], exp_rem[s]);
    assert (int'(b.count) == n)
      else fail_check($sformatf("slot %0d block count: expected %0d, got %0d", s, n, b.count));
    assert (b.section == exp_sec[s])
      else fail_check($sformatf("slot %0d section: expected %0d, got %0d", s, exp_sec[s],
                                b.section));
    exp_addr[s]       = exp_addr[s] + 32'(n);
    exp_rem[s]        = exp_rem[s] - n;
    chan_seen[b.chan] = 1'b1;
  endtask

  task automatic check_irq(input logic [SLOT_W-1:0] s);
    assert (pending[s]) else fail_check($sformatf("irq for slot %0d with nothing pending", s));
    assert (exp_rem[s] == 0)
      else fail_check($sformatf("irq for slot %0d with %0d words not moved", s, exp_rem[s]));
    pending[s] = 1'b0;
  endtask

  // ------------------------------------------------------------
  // behavioral block mover
  // ------------------------------------------------------------
  always @(negedge CLK)
  begin
    if (RST && blk_valid && !blk_ready)
      stall_seen = 1'b1;
    if (RST && blk_valid && blk_ready)  // taken at the next edge
    begin
      check_block(blk_req);
      pend_chan.push_back(blk_req.chan);
      pend_due.push_back(cycle + 2 + int'({$random(seed)} % 5));
    end
    if (RST && irq)
      check_irq(irq_slot);
  end

  always @(posedge CLK)
  begin
    #1;
    blk_done = 1'b0;
    if (pend_chan.size() > 0 && cycle >= pend_due[0])
    begin
      blk_done      = 1'b1;
      blk_done_chan = pend_chan.pop_front();
      void'(pend_due.pop_front());
    end
    blk_ready = ({$random(seed)} % 4) != 0;  // back-pressure now and then
  end

  assert property (@(posedge CLK) disable iff (!RST)
                   (blk_valid && !blk_ready) |=> (blk_valid && $stable(blk_req)))
    else fail_check("blk_req dropped or changed while stalled");

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  initial
  begin
    logic        err;
    logic [31:0] rd;
    logic [31:0] a;

    RST           = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    blk_ready     = 1'b0;
    blk_done      = 1'b0;
    blk_done_chan = '0;
    repeat (8) @(posedge CLK);
    #1;
    RST = 1'b1;
    @(negedge CLK);
    assert (!blk_valid && !irq && !pslverr) else fail_check("outputs not low after reset");
    for (int s = 0; s < NUM_SLOTS; s++)
    begin
      apb_read(reg_addr(s, REG_CTRL), rd);
      assert (rd[31] === 1'b0) else fail_check($sformatf("slot %0d active after reset", s));
    end

    // register write and read back, slot left inactive
    apb_write(reg_addr(0, REG_ADDR), 32'h0000_1234, err);
    assert (!err) else fail_check("pslverr on write to idle slot");
    apb_write(reg_addr(0, REG_CTRL), {1'b0, 5'd0, 2'd1, 24'd100}, err);
    assert (!err) else fail_check("pslverr on write to idle slot");
    apb_read(reg_addr(0, REG_ADDR), rd);
    assert (rd == 32'h0000_1234)
      else fail_check($sformatf("REG_ADDR: expected 00001234, got %h", rd));
    apb_read(reg_addr(0, REG_CTRL), rd);
    assert (rd == {1'b0, 5'd0, 2'd1, 24'd100})
      else fail_check($sformatf("REG_CTRL: expected %h, got %h", {8'h01, 24'd100}, rd));

    // one descriptor across several pages
    load_desc(1, 32'h0000_20F0, 600, 2'd2);
    while (pending != '0)
      @(posedge CLK);
    apb_read(reg_addr(1, REG_CTRL), rd);
    assert (rd == {1'b0, 5'd0, 2'd2, 24'd600})
      else fail_check($sformatf("slot 1 after irq: expected %h, got %h", {8'h02, 24'd600}, rd));

    // all eight slots at once
    for (int s = 0; s < NUM_SLOTS; s++)
    begin
      a = 32'((s + 1) << 16) + 32'(s * 37);
      load_desc(s, a, 150 + s * 45, 2'(s % 4));
    end

    // slot 7 is still busy here
    apb_write(reg_addr(7, REG_ADDR), 32'hDEAD_0000, err);
    assert (err) else fail_check("no pslverr on address write to active slot");
    apb_write(reg_addr(7, REG_CTRL), {1'b1, 5'd0, 2'd0, 24'd5}, err);
    assert (err) else fail_check("no pslverr on control write to active slot");
    apb_read(reg_addr(7, REG_ADDR), rd);
    assert (rd == desc_addr[7])
      else fail_check($sformatf("slot 7 address: expected %h, got %h", desc_addr[7], rd));
    apb_read(reg_addr(7, REG_CTRL), rd);
    assert (rd[25:0] == {2'd3, 24'(desc_len[7])})
      else fail_check($sformatf("slot 7 control changed to %h", rd));

    while (pending != '0)
      @(posedge CLK);
    assert ($countones(chan_seen) > 1) else fail_check("all blocks came from one channel");
    assert (stall_seen) else fail_check("mover never stalled a request");
    for (int s = 0; s < NUM_SLOTS; s++)
    begin
      apb_read(reg_addr(s, REG_CTRL), rd);
      assert (rd == {1'b0, 5'd0, 2'(s % 4), 24'(desc_len[s])})
        else fail_check($sformatf("slot %0d control after finish: got %h", s, rd));
    end
    repeat (4) @(posedge CLK);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: compile.f
hdl/dma_sched_pkg.sv
hdl/desc_mem.sv
hdl/carousel_sched.sv
hdl/block_exec.sv
hdl/block_arbiter.sv
hdl/dma_sched_top.sv
test/tb_dma_sched.sv

// File: run_sim.sh
#!/bin/sh
# build and run the DMA scheduler testbench with Verilator
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_sched \
       -f compile.f -o sim_dma_sched \
  && ./obj_dir/sim_dma_sched | tee /dev/stderr | grep -q "Simulation PASSED" \
  && echo "run_sim: pass" \
  || { echo "run_sim: fail"; exit 1; }
